/* Makefile */
TOP = tb_video_out

.PHONY: all lint clean

# Build, run, then decide pass or fail from the log
all:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing --top-module video_out_top \
		video_pkg.sv wb_regs_pkg.sv video_out_ctrl.sv rgb_to_ycbcr.sv \
		chroma_422_packer.sv sync_delay.sv video_out_top.sv

clean:
	rm -rf obj_dir sim.log

/* chroma_422_packer.sv */
////////////////////////////////////////////////////////////
// 4:2:2 packer, Cb on even and Cr on odd pixels of a run
// Chroma is taken from each pixel, not averaged over a pair
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module chroma_422_packer
  import video_pkg::*;
(
  input  logic         video_clk_148,
  input  logic         video_reset_148,
  input  ycbcr_pixel_t i_pix,
  input  logic         i_de,
  input  logic         i_enable,
  output hdmi_data_t   o_txd,
  output logic         o_de
);

  // Low on the first pixel of every active run
  logic parity_q;

  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      parity_q <= 1'b0;
      o_de     <= 1'b0;
      o_txd    <= '0;
    end
    else
    begin
      parity_q <= i_de & ~parity_q;
      o_de     <= i_de & i_enable;
      // Chroma in the upper byte, luma in the lower
      if (i_de && i_enable)
      begin
        o_txd <= {(parity_q ? i_pix.cr : i_pix.cb), i_pix.y};
      end
      else
      begin
        o_txd <= '0;
      end
    end
  end

endmodule

/* filelist.f */
video_pkg.sv
wb_regs_pkg.sv
video_out_ctrl.sv
rgb_to_ycbcr.sv
chroma_422_packer.sv
sync_delay.sv
video_out_top.sv
tb_video_out.sv

/* rgb_to_ycbcr.sv */
////////////////////////////////////////////////////////////
// Three-stage RGB to YCbCr, one pixel per clock
// Coefficient set keeps all results in 0..255, no clamp
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module rgb_to_ycbcr
  import video_pkg::*;
(
  input  logic         video_clk_148,
  input  logic         video_reset_148,
  input  rgb_pixel_t   i_rgb,
  input  logic         i_de,
  output ycbcr_pixel_t o_pix,
  output logic         o_de
);

  // Rows are Y, Cb, Cr and columns are R, G, B
  prod_t                   prod_q [3][3];
  sum_t                    sum_q  [3];
  logic [CONV_LATENCY-1:0] de_q;

  // Unsigned component times signed coefficient
  function automatic prod_t mul(input comp_t c, input coef_t k);
    return $signed({1'b0, c}) * k;
  endfunction

  //////////////////////////////////////////////////////////
  // Stage 1, products
  always_ff @(posedge video_clk_148)
  begin
    prod_q[0][0] <= mul(i_rgb.r, KY_R);
    prod_q[0][1] <= mul(i_rgb.g, KY_G);
    prod_q[0][2] <= mul(i_rgb.b, KY_B);
    prod_q[1][0] <= mul(i_rgb.r, KCB_R);
    prod_q[1][1] <= mul(i_rgb.g, KCB_G);
    prod_q[1][2] <= mul(i_rgb.b, KCB_B);
    prod_q[2][0] <= mul(i_rgb.r, KCR_R);
    prod_q[2][1] <= mul(i_rgb.g, KCR_G);
    prod_q[2][2] <= mul(i_rgb.b, KCR_B);
  end

  // Stage 2, sums
  always_ff @(posedge video_clk_148)
  begin
    for (int i = 0; i < 3; i++)
    begin
      sum_q[i] <= sum_t'(prod_q[i][0]) + sum_t'(prod_q[i][1]) + sum_t'(prod_q[i][2]);
    end
  end

  // Stage 3, drop the x256 scale and centre the chroma
  always_ff @(posedge video_clk_148)
  begin
    o_pix.y  <= comp_t'(sum_q[0] >>> 8);
    o_pix.cb <= comp_t'((sum_q[1] >>> 8) + CHROMA_OFFSET);
    o_pix.cr <= comp_t'((sum_q[2] >>> 8) + CHROMA_OFFSET);
  end

  //////////////////////////////////////////////////////////
  // Data enable follows the three stages
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      de_q <= '0;
    end
    else
    begin
      de_q <= {de_q[CONV_LATENCY-2:0], i_de};
    end
  end

  assign o_de = de_q[CONV_LATENCY-1];

endmodule

/* sync_delay.sv */
////////////////////////////////////////////////////////////
// Delays the syncs by DEPTH clocks, DEPTH must be 1 or more
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sync_delay
  import video_pkg::*;
#(
  parameter int DEPTH = PIPE_LATENCY
)
(
  input  logic        video_clk_148,
  input  logic        video_reset_148,
  input  video_sync_t i_sync,
  output video_sync_t o_sync
);

  video_sync_t sync_q [DEPTH];

  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      for (int i = 0; i < DEPTH; i++)
      begin
        sync_q[i] <= '0;
      end
    end
    else
    begin
      sync_q[0] <= i_sync;
      for (int i = 1; i < DEPTH; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign o_sync = sync_q[DEPTH-1];

endmodule

/* tb_video_out.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the video output stage
// Outputs are sampled 1 ns after the edge and before new inputs
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_video_out
  import video_pkg::*;
  import wb_regs_pkg::*;
();

  localparam int CLK_PERIOD_NS  = 40;
  localparam int RESET_CYCLES   = 4;
  localparam int EXP_LATENCY    = 4;
  localparam int WB_TIMEOUT     = 8;
  localparam int STREAM_DEPTH   = 128;
  localparam int N_WB_ACCESSES  = 16;
  localparam int N_STREAMS      = 6;
  localparam int MARGIN_CYCLES  = 100;
  localparam int WATCHDOG_CYCLES = N_WB_ACCESSES * (WB_TIMEOUT + 2)
                                 + N_STREAMS * (STREAM_DEPTH + EXP_LATENCY)
                                 + 2 * (RESET_CYCLES + 1) + MARGIN_CYCLES;

  logic        video_clk_148;
  logic        video_reset_148;
  rgb_pixel_t  rgb;
  logic        de;
  video_sync_t sync;
  wb_req_t     wb;
  logic        wb_ack;
  wb_data_t    wb_dat;
  hdmi_data_t  hdmi_txd;
  logic        hdmi_de;
  logic        hdmi_vsync;
  logic        hdmi_hsync;

  int   errors;
  int   tests_run;
  logic exp_enable;

  // Stimulus buffer with one entry per clock
  rgb_pixel_t  s_rgb  [STREAM_DEPTH];
  logic        s_de   [STREAM_DEPTH];
  video_sync_t s_sync [STREAM_DEPTH];
  logic        s_odd  [STREAM_DEPTH];
  int          s_len;

  video_out_top i_video_out_top (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_rgb           (rgb),
    .i_de            (de),
    .i_sync          (sync),
    .i_wb            (wb),
    .o_wb_ack        (wb_ack),
    .o_wb_dat        (wb_dat),
    .o_hdmi_txd      (hdmi_txd),
    .o_hdmi_de       (hdmi_de),
    .o_hdmi_vsync    (hdmi_vsync),
    .o_hdmi_hsync    (hdmi_hsync)
  );

  always #(CLK_PERIOD_NS / 2) video_clk_148 = ~video_clk_148;

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
    $display("Watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  task automatic next_cycle();
    @(posedge video_clk_148);
    #1;
  endtask

  task automatic reset_dut();
    video_reset_148 = 1'b1;
    repeat (RESET_CYCLES) next_cycle();
    video_reset_148 = 1'b0;
    next_cycle();
  endtask

  task automatic value_error(input string sig, input int idx, input logic [31:0] exp,
                             input logic [31:0] got);
    $display("Error %s at %0d expected %h got %h", sig, idx, exp, got);
    errors++;
  endtask

  task automatic end_test(input string name, input int start_errors);
    $display("%s finished with %0d errors", name, errors - start_errors);
    tests_run++;
  endtask

  // Full-range BT.601 with coefficients x256 and chroma centred on 128
  function automatic ycbcr_pixel_t ycbcr_model(input rgb_pixel_t p);
    int r;
    int g;
    int b;
    int y;
    int cb;
    int cr;
    ycbcr_pixel_t q;
    r = int'(p.r);
    g = int'(p.g);
    b = int'(p.b);
    y  = (77 * r + 150 * g + 29 * b) >>> 8;
    cb = ((128 * b - 43 * r - 85 * g) >>> 8) + 128;
    cr = ((128 * r - 107 * g - 21 * b) >>> 8) + 128;
    q.y  = y[7:0];
    q.cb = cb[7:0];
    q.cr = cr[7:0];
    return q;
  endfunction

  // One Wishbone classic access where the master drops stb after ack
  task automatic wb_transfer(input logic write, input wb_addr_t addr, input wb_data_t wdata,
                             output wb_data_t rdata);
    int waited;
    waited = 0;
    wb.cyc = 1'b1;
    wb.stb = 1'b1;
    wb.we  = write;
    wb.adr = addr;
    wb.dat = wdata;
    next_cycle();
    while (!wb_ack && waited < WB_TIMEOUT)
    begin
      next_cycle();
      waited++;
    end
    if (!wb_ack)
    begin
      $display("No ack for the access at address %h", addr);
      errors++;
    end
    rdata  = wb_dat;
    wb.cyc = 1'b0;
    wb.stb = 1'b0;
    wb.we  = 1'b0;
    next_cycle();
    if (wb_ack)
    begin
      $display("Ack held for more than one cycle at address %h", addr);
      errors++;
    end
  endtask

  task automatic wb_write(input wb_addr_t addr, input wb_data_t wdata);
    wb_data_t unused;
    wb_transfer(1'b1, addr, wdata, unused);
  endtask

  task automatic wb_read_check(input wb_addr_t addr, input wb_data_t exp);
    wb_data_t rd;
    wb_transfer(1'b0, addr, '0, rd);
    if (rd !== exp)
    begin
      value_error("o_wb_dat", int'(addr), exp, rd);
    end
  endtask

  task automatic push_cycle(input logic d, input logic vs, input logic hs, input rgb_pixel_t p);
    if (s_len >= STREAM_DEPTH)
    begin
      $display("Stimulus buffer overflow");
      errors++;
      return;
    end
    s_de[s_len]      = d;
    s_sync[s_len].vs = vs;
    s_sync[s_len].hs = hs;
    s_rgb[s_len]     = p;
    // Cb on the first pixel of a run, then alternating
    s_odd[s_len] = 1'b0;
    if (d && s_len > 0)
    begin
      if (s_de[s_len-1])
      begin
        s_odd[s_len] = ~s_odd[s_len-1];
      end
    end
    s_len++;
  endtask

  task automatic push_idle(input int n);
    for (int i = 0; i < n; i++)
    begin
      push_cycle(1'b0, 1'b0, 1'b0, '0);
    end
  endtask

  task automatic push_random_run(input int n);
    logic [31:0] rnd;
    for (int i = 0; i < n; i++)
    begin
      rnd = $urandom();
      push_cycle(1'b1, 1'b0, 1'b0, rgb_pixel_t'(rnd[23:0]));
    end
  endtask

  task automatic push_sync_pattern();
    push_idle(1);
    push_cycle(1'b0, 1'b1, 1'b0, '0);
    push_idle(2);
    push_cycle(1'b0, 1'b0, 1'b1, '0);
    push_cycle(1'b0, 1'b1, 1'b1, '0);
    push_idle(3);
  endtask

  ////////////////////////////////////////////////////////////
  // Plays the buffer and checks every output EXP_LATENCY later
  task automatic run_stream();
    int           idx;
    ycbcr_pixel_t m;
    hdmi_data_t   exp_txd;
    logic         exp_de;
    for (int c = 0; c < s_len + EXP_LATENCY; c++)
    begin
      next_cycle();
      idx = c - EXP_LATENCY;
      if (idx >= 0)
      begin
        exp_de  = s_de[idx] & exp_enable;
        m       = ycbcr_model(s_rgb[idx]);
        exp_txd = '0;
        if (exp_de)
        begin
          exp_txd = {(s_odd[idx] ? m.cr : m.cb), m.y};
        end
        if (hdmi_de !== exp_de)
        begin
          value_error("o_hdmi_de", idx, 32'(exp_de), 32'(hdmi_de));
        end
        if (hdmi_txd !== exp_txd)
        begin
          value_error("o_hdmi_txd", idx, 32'(exp_txd), 32'(hdmi_txd));
        end
        if (hdmi_vsync !== s_sync[idx].vs)
        begin
          value_error("o_hdmi_vsync", idx, 32'(s_sync[idx].vs), 32'(hdmi_vsync));
        end
        if (hdmi_hsync !== s_sync[idx].hs)
        begin
          value_error("o_hdmi_hsync", idx, 32'(s_sync[idx].hs), 32'(hdmi_hsync));
        end
      end
      if (c < s_len)
      begin
        rgb  = s_rgb[c];
        de   = s_de[c];
        sync = s_sync[c];
      end
      else
      begin
        rgb  = '0;
        de   = 1'b0;
        sync = '0;
      end
    end
    s_len = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // Tests

  task automatic test_reset_state();
    int start;
    start = errors;
    if (hdmi_de !== 1'b0)
    begin
      value_error("o_hdmi_de", 0, 32'h0, 32'(hdmi_de));
    end
    if (hdmi_txd !== '0)
    begin
      value_error("o_hdmi_txd", 0, 32'h0, 32'(hdmi_txd));
    end
    if (hdmi_vsync !== 1'b0 || hdmi_hsync !== 1'b0)
    begin
      value_error("o_hdmi_vsync/hsync", 0, 32'h0, 32'({hdmi_vsync, hdmi_hsync}));
    end
    if (wb_ack !== 1'b0)
    begin
      value_error("o_wb_ack", 0, 32'h0, 32'(wb_ack));
    end
    if (wb_dat !== '0)
    begin
      value_error("o_wb_dat", 0, 32'h0, wb_dat);
    end
    wb_read_check(REG_CTRL_ADDR, 32'h0);
    wb_read_check(REG_FRAMES_ADDR, 32'h0);
    wb_read_check(REG_LINES_ADDR, 32'h0);
    end_test("reset_state", start);
  endtask

  task automatic test_register_access();
    int start;
    start = errors;
    wb_write(REG_CTRL_ADDR, 32'h1);
    wb_read_check(REG_CTRL_ADDR, 32'h1);
    // Follows a read of one, so stale read data shows up
    wb_read_check(4'hc, 32'h0);
    // Read-only counter keeps its value
    wb_write(REG_FRAMES_ADDR, 32'h0000_00a5);
    wb_read_check(REG_FRAMES_ADDR, 32'h0);
    exp_enable = 1'b1;
    end_test("register_access", start);
  endtask

  task automatic test_pixel_path();
    int start;
    start = errors;
    push_idle(2);
    push_random_run(16);
    push_idle(3);
    // Odd run length so the next run must restart on Cb
    push_random_run(5);
    push_idle(2);
    push_random_run(1);
    push_idle(1);
    run_stream();
    end_test("pixel_path", start);
  endtask

  task automatic test_sync_delay();
    int start;
    start = errors;
    push_sync_pattern();
    run_stream();
    wb_write(REG_CTRL_ADDR, 32'h0);
    exp_enable = 1'b0;
    push_sync_pattern();
    run_stream();
    end_test("sync_delay", start);
  endtask

  task automatic test_output_disabled();
    int start;
    start = errors;
    wb_read_check(REG_CTRL_ADDR, 32'h0);
    push_idle(1);
    push_random_run(8);
    push_idle(1);
    run_stream();
    end_test("output_disabled", start);
  endtask

  task automatic test_frame_counters();
    int start;
    int lines [3];
    start = errors;
    lines = '{3, 5, 2};
    reset_dut();
    exp_enable = 1'b0;
    for (int f = 0; f < 3; f++)
    begin
      push_cycle(1'b0, 1'b1, 1'b0, '0);
      push_idle(1);
      for (int l = 0; l < lines[f]; l++)
      begin
        push_cycle(1'b0, 1'b0, 1'b1, '0);
        push_random_run(4);
        push_idle(1);
      end
    end
    run_stream();
    // Third vsync latched the lines of the second frame
    wb_read_check(REG_FRAMES_ADDR, 32'd3);
    wb_read_check(REG_LINES_ADDR, 32'(lines[1]));
    end_test("frame_counters", start);
  endtask

  initial
  begin
    video_clk_148   = 1'b0;
    video_reset_148 = 1'b1;
    rgb             = '0;
    de              = 1'b0;
    sync            = '0;
    wb              = '0;
    errors          = 0;
    tests_run       = 0;
    exp_enable      = 1'b0;
    s_len           = 0;
    void'($urandom(32'h2e891ae3));
    reset_dut();
    test_reset_state();
    test_register_access();
    test_pixel_path();
    test_sync_delay();
    test_output_disabled();
    test_frame_counters();
    $display("Tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* video_out_ctrl.sv */
////////////////////////////////////////////////////////////
// Wishbone classic slave, one wait state, ack for one cycle
// Counters see the raw input syncs, not the delayed ones
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module video_out_ctrl
  import video_pkg::*;
  import wb_regs_pkg::*;
(
  input  logic        video_clk_148,
  input  logic        video_reset_148,
  input  wb_req_t     i_wb,
  input  video_sync_t i_sync,
  input  logic        i_de,
  output logic        o_wb_ack,
  output wb_data_t    o_wb_dat,
  output logic        o_enable
);

  logic     wb_access;
  logic     vs_q;
  logic     de_q;
  logic     vs_rise;
  logic     de_rise;
  count_t   frame_cnt;
  count_t   line_cnt;
  count_t   line_latch;
  wb_data_t rd_data;

  // New request only while ack is low, so each access acks once
  assign wb_access = i_wb.cyc & i_wb.stb & ~o_wb_ack;

  assign vs_rise = i_sync.vs & ~vs_q;
  assign de_rise = i_de & ~de_q;

  //////////////////////////////////////////////////////////
  // Register read mux
  always_comb
  begin
    rd_data = '0;
    case (i_wb.adr)
      REG_CTRL_ADDR:   rd_data[CTRL_ENABLE_BIT] = o_enable;
      REG_FRAMES_ADDR: rd_data[$bits(count_t)-1:0] = frame_cnt;
      REG_LINES_ADDR:  rd_data[$bits(count_t)-1:0] = line_latch;
      default:         rd_data = '0;
    endcase
  end

  //////////////////////////////////////////////////////////
  // Bus side
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      o_wb_ack <= 1'b0;
      o_wb_dat <= '0;
      o_enable <= 1'b0;
    end
    else
    begin
      o_wb_ack <= wb_access;
      if (wb_access)
      begin
        o_wb_dat <= rd_data;
        // Only REG_CTRL is writable
        if (i_wb.we && (i_wb.adr == REG_CTRL_ADDR))
        begin
          o_enable <= i_wb.dat[CTRL_ENABLE_BIT];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////
  // Frame and line counters
  always_ff @(posedge video_clk_148)
  begin
    if (video_reset_148)
    begin
      vs_q       <= 1'b0;
      de_q       <= 1'b0;
      frame_cnt  <= '0;
      line_cnt   <= '0;
      line_latch <= '0;
    end
    else
    begin
      vs_q <= i_sync.vs;
      de_q <= i_de;
      if (vs_rise)
      begin
        frame_cnt  <= frame_cnt + 1'b1;
        line_latch <= line_cnt;
        line_cnt   <= '0;
      end
      else if (de_rise)
      begin
        // Each active run counts as one line
        line_cnt <= line_cnt + 1'b1;
      end
    end
  end

endmodule

/* video_out_top.sv */
////////////////////////////////////////////////////////////
// Video output stage, RGB in and 16-bit YCbCr 4:2:2 out
// No back-pressure, one pixel per clock, PIPE_LATENCY delay
////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module video_out_top
  import video_pkg::*;
  import wb_regs_pkg::*;
(
  input  logic        video_clk_148,
  input  logic        video_reset_148,
  input  rgb_pixel_t  i_rgb,
  input  logic        i_de,
  input  video_sync_t i_sync,
  input  wb_req_t     i_wb,
  output logic        o_wb_ack,
  output wb_data_t    o_wb_dat,
  output hdmi_data_t  o_hdmi_txd,
  output logic        o_hdmi_de,
  output logic        o_hdmi_vsync,
  output logic        o_hdmi_hsync
);

  logic         out_enable;
  ycbcr_pixel_t conv_pix;
  logic         conv_de;
  video_sync_t  sync_dly;

  video_out_ctrl i_video_out_ctrl (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_wb            (i_wb),
    .i_sync          (i_sync),
    .i_de            (i_de),
    .o_wb_ack        (o_wb_ack),
    .o_wb_dat        (o_wb_dat),
    .o_enable        (out_enable)
  );

  rgb_to_ycbcr i_rgb_to_ycbcr (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_rgb           (i_rgb),
    .i_de            (i_de),
    .o_pix           (conv_pix),
    .o_de            (conv_de)
  );

  chroma_422_packer i_chroma_422_packer (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_pix           (conv_pix),
    .i_de            (conv_de),
    .i_enable        (out_enable),
    .o_txd           (o_hdmi_txd),
    .o_de            (o_hdmi_de)
  );

  // Syncs bypass the datapath, delayed to match it
  sync_delay #(
    .DEPTH (PIPE_LATENCY)
  ) i_sync_delay (
    .video_clk_148   (video_clk_148),
    .video_reset_148 (video_reset_148),
    .i_sync          (i_sync),
    .o_sync          (sync_dly)
  );

  assign o_hdmi_vsync = sync_dly.vs;
  assign o_hdmi_hsync = sync_dly.hs;

endmodule

/* video_pkg.sv */
////////////////////////////////////////////////////////////
// Pixel and sync types for the 8-bit video output path
// Colour maths is full-range BT.601 with coefficients x256
////////////////////////////////////////////////////////////
package video_pkg;

  // Widths with a meaning of their own
  typedef logic [7:0]         comp_t;
  typedef logic [15:0]        hdmi_data_t;
  typedef logic signed [8:0]  coef_t;
  typedef logic signed [16:0] prod_t;
  typedef logic signed [17:0] sum_t;

  typedef struct packed {
    comp_t r;
    comp_t g;
    comp_t b;
  } rgb_pixel_t;

  typedef struct packed {
    comp_t y;
    comp_t cb;
    comp_t cr;
  } ycbcr_pixel_t;

  typedef struct packed {
    logic vs;
    logic hs;
  } video_sync_t;

  //////////////////////////////////////////////////////////
  // Pipeline depths, in clock cycles
  localparam int CONV_LATENCY = 3;
  localparam int PACK_LATENCY = 1;
  localparam int PIPE_LATENCY = CONV_LATENCY + PACK_LATENCY;

  //////////////////////////////////////////////////////////
  // Conversion coefficients, scaled by 256
  localparam coef_t KY_R  = 9'sd77;
  localparam coef_t KY_G  = 9'sd150;
  localparam coef_t KY_B  = 9'sd29;
  localparam coef_t KCB_R = -9'sd43;
  localparam coef_t KCB_G = -9'sd85;
  localparam coef_t KCB_B = 9'sd128;
  localparam coef_t KCR_R = 9'sd128;
  localparam coef_t KCR_G = -9'sd107;
  localparam coef_t KCR_B = -9'sd21;

  // Chroma is centred on mid-scale
  localparam sum_t CHROMA_OFFSET = 18'sd128;

endpackage

/* wb_regs_pkg.sv */
////////////////////////////////////////////////////////////
// Wishbone classic types and register map of the video slave
// Byte addresses, 32-bit data, no byte selects
////////////////////////////////////////////////////////////
package wb_regs_pkg;

  typedef logic [3:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // Request signals from the bus master
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  // Status counters wrap at 16 bits
  typedef logic [15:0] count_t;

  //////////////////////////////////////////////////////////
  // Register map
  localparam wb_addr_t REG_CTRL_ADDR   = 4'h0;
  localparam wb_addr_t REG_FRAMES_ADDR = 4'h4;
  localparam wb_addr_t REG_LINES_ADDR  = 4'h8;

  // REG_CTRL fields
  localparam int CTRL_ENABLE_BIT = 0;

endpackage
